// ==== common/amber_sys_consts.svh ====
`ifndef AMBER_SYS_CONSTS_SVH
`define AMBER_SYS_CONSTS_SVH

// Wishbone data and byte select widths
`define WB_DWIDTH           32
`define WB_SWIDTH           4

// Boot memory depth in words
`define BOOT_MEM_WORDS      256

// Address bits that pick a slave, and the region codes
`define SLAVE_REGION_MSB    31
`define SLAVE_REGION_LSB    24
`define BOOT_MEM_REGION     8'h00
`define TIMER_REGION        8'h13
`define IC_REGION           8'h14

// Timer register offsets
`define TM_LOAD             8'h00
`define TM_VALUE            8'h04
`define TM_CTRL             8'h08
`define TM_CLEAR            8'h0C

// Interrupt controller register offsets
`define IC_IRQ_STATUS       8'h00
`define IC_FIRQ_STATUS      8'h04
`define IC_RAW_STATUS       8'h08
`define IC_IRQ_EN_SET       8'h0C
`define IC_IRQ_EN_CLR       8'h10
`define IC_FIRQ_EN_SET      8'h14
`define IC_FIRQ_EN_CLR      8'h18
`define IC_SOFT_SET         8'h1C
`define IC_SOFT_CLR         8'h20

// Interrupt source bit positions
`define IRQ_SOFT_BIT        0
`define IRQ_TIMER_BIT       1
`define IRQ_EXT0_BIT        2
`define IRQ_EXT1_BIT        3
`define IRQ_SOURCES         4

`endif

// ==== common/amber_sys_pkg.sv ====
`include "amber_sys_consts.svh"

package amber_sys_pkg;

    // ------------------------------------------------------------
    // Wishbone bus fields
    // ------------------------------------------------------------

    // Byte address, the top byte picks the slave
    typedef logic [31:0]               wb_adr_t;

    // One data word on the bus
    typedef logic [`WB_DWIDTH-1:0]     wb_dat_t;

    // Byte lane selects
    typedef logic [`WB_SWIDTH-1:0]     wb_sel_t;

    // Decoded target of the current access
    typedef enum logic [1:0] {
        SLV_BOOT  = 2'd0,
        SLV_TIMER = 2'd1,
        SLV_IC    = 2'd2,
        SLV_NONE  = 2'd3
    } slave_sel_e;

    // ------------------------------------------------------------
    // Interrupts
    // ------------------------------------------------------------

    // One bit per source, positions from the IRQ_*_BIT defines
    typedef logic [`IRQ_SOURCES-1:0]   irq_src_t;

endpackage

// ==== source/wb_slave_decoder.sv ====
`timescale 1ns/1ps

`include "amber_sys_consts.svh"

module wb_slave_decoder (
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    // From the master
    input  amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,

    // Per slave strobes
    output logic                    o_boot_stb,
    output logic                    o_timer_stb,
    output logic                    o_ic_stb,

    // Slave responses
    input  amber_sys_pkg::wb_dat_t  i_boot_dat,
    input  amber_sys_pkg::wb_dat_t  i_timer_dat,
    input  amber_sys_pkg::wb_dat_t  i_ic_dat,
    input  logic                    i_boot_ack,
    input  logic                    i_timer_ack,
    input  logic                    i_ic_ack,

    // Back to the master
    output amber_sys_pkg::wb_dat_t  o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_wb_err
);

    import amber_sys_pkg::*;

    logic [`SLAVE_REGION_MSB-`SLAVE_REGION_LSB:0] region;
    slave_sel_e                                   slave_sel;
    logic                                         bus_req;
    logic                                         none_stb;
    logic                                         err_q;

    assign region  = i_wb_adr[`SLAVE_REGION_MSB:`SLAVE_REGION_LSB];
    assign bus_req = i_wb_cyc && i_wb_stb;

    always_comb begin
        case (region)
            `BOOT_MEM_REGION: slave_sel = SLV_BOOT;
            `TIMER_REGION:    slave_sel = SLV_TIMER;
            `IC_REGION:       slave_sel = SLV_IC;
            default:          slave_sel = SLV_NONE;
        endcase
    end

    // ------------------------------------------------------------
    // Strobe fan out
    // ------------------------------------------------------------
    assign o_boot_stb  = bus_req && (slave_sel == SLV_BOOT);
    assign o_timer_stb = bus_req && (slave_sel == SLV_TIMER);
    assign o_ic_stb    = bus_req && (slave_sel == SLV_IC);
    assign none_stb    = bus_req && (slave_sel == SLV_NONE);

    // Unmapped access answers like a slave, one pulse per transfer
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= none_stb && !err_q;
        end
    end

    assign o_wb_err = err_q;

    // ------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------
    always_comb begin
        case (slave_sel)
            SLV_BOOT: begin
                o_wb_dat = i_boot_dat;
                o_wb_ack = i_boot_ack;
            end
            SLV_TIMER: begin
                o_wb_dat = i_timer_dat;
                o_wb_ack = i_timer_ack;
            end
            SLV_IC: begin
                o_wb_dat = i_ic_dat;
                o_wb_ack = i_ic_ack;
            end
            default: begin
                o_wb_dat = '0;
                o_wb_ack = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/boot_mem.sv ====
`timescale 1ns/1ps

`include "amber_sys_consts.svh"

module boot_mem (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  amber_sys_pkg::wb_sel_t  i_wb_sel,
    input  logic                    i_wb_we,
    input  logic                    i_wb_stb,
    input  amber_sys_pkg::wb_dat_t  i_wb_dat,
    output amber_sys_pkg::wb_dat_t  o_wb_dat,
    output logic                    o_wb_ack
);

    import amber_sys_pkg::*;

    localparam int ADR_BITS = $clog2(`BOOT_MEM_WORDS);

    wb_dat_t             mem [0:`BOOT_MEM_WORDS-1];
    logic [ADR_BITS-1:0] word_idx;
    logic                wb_start;

    // Upper address bits ignored, so accesses wrap in the region
    assign word_idx = i_wb_adr[ADR_BITS+1:2];

    // New transfer only, not the strobe still high during ack
    assign wb_start = i_wb_stb && !o_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_start;
        end
    end

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (wb_start && i_wb_we) begin
            for (int b = 0; b < `WB_SWIDTH; b++) begin
                if (i_wb_sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_wb_dat[b*8 +: 8];
                end
            end
        end
        // Read word lines up with the ack
        if (wb_start && !i_wb_we) begin
            o_wb_dat <= mem[word_idx];
        end
    end

endmodule

// ==== timer/timer_module.sv ====
`timescale 1ns/1ps

`include "amber_sys_consts.svh"

module timer_module (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  logic                    i_wb_we,
    input  logic                    i_wb_stb,
    input  amber_sys_pkg::wb_dat_t  i_wb_dat,
    output amber_sys_pkg::wb_dat_t  o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_timer_int
);

    import amber_sys_pkg::*;

    wb_dat_t    load_q;
    wb_dat_t    value_q;
    logic       en_q;
    logic       pending_q;
    logic       wb_start;
    logic       wb_wr;
    logic       ctrl_start;
    logic [7:0] reg_ofs;

    assign reg_ofs    = i_wb_adr[7:0];
    assign wb_start   = i_wb_stb && !o_wb_ack;
    assign wb_wr      = wb_start && i_wb_we;

    // Enabling write restarts the count from the load value
    assign ctrl_start = wb_wr && (reg_ofs == `TM_CTRL) && i_wb_dat[0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_start;
        end
    end

    // ------------------------------------------------------------
    // Registers and countdown
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_q    <= '0;
            value_q   <= '0;
            en_q      <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (wb_wr && (reg_ofs == `TM_LOAD)) begin
                load_q <= i_wb_dat;
            end
            if (wb_wr && (reg_ofs == `TM_CTRL)) begin
                en_q <= i_wb_dat[0];
            end

            if (ctrl_start) begin
                value_q <= load_q;
            end else if (en_q) begin
                // Zero reached, reload on the following edge
                if (value_q == '0) begin
                    value_q <= load_q;
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end

            // A fresh expiry wins over a clear in the same cycle
            if (en_q && (value_q == '0)) begin
                pending_q <= 1'b1;
            end else if (wb_wr && (reg_ofs == `TM_CLEAR)) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign o_timer_int = pending_q;

    // Read data
    always_ff @(posedge i_clk) begin
        if (wb_start && !i_wb_we) begin
            case (reg_ofs)
                `TM_LOAD:  o_wb_dat <= load_q;
                `TM_VALUE: o_wb_dat <= value_q;
                `TM_CTRL:  o_wb_dat <= wb_dat_t'(en_q);
                default:   o_wb_dat <= '0;
            endcase
        end
    end

endmodule

// ==== source/interrupt_controller.sv ====
`timescale 1ns/1ps

`include "amber_sys_consts.svh"

module interrupt_controller (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  logic                    i_wb_we,
    input  logic                    i_wb_stb,
    input  amber_sys_pkg::wb_dat_t  i_wb_dat,
    input  logic                    i_timer_int,
    input  logic [1:0]              i_ext_irq,
    output amber_sys_pkg::wb_dat_t  o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_irq,
    output logic                    o_firq
);

    import amber_sys_pkg::*;

    irq_src_t   raw_status;
    irq_src_t   irq_status;
    irq_src_t   firq_status;
    irq_src_t   irq_en_q;
    irq_src_t   firq_en_q;
    irq_src_t   wr_bits;
    logic       soft_q;
    logic       wb_start;
    logic       wb_wr;
    logic [7:0] reg_ofs;

    assign reg_ofs  = i_wb_adr[7:0];
    assign wb_start = i_wb_stb && !o_wb_ack;
    assign wb_wr    = wb_start && i_wb_we;
    assign wr_bits  = i_wb_dat[`IRQ_SOURCES-1:0];

    always_comb begin
        raw_status                 = '0;
        raw_status[`IRQ_SOFT_BIT]  = soft_q;
        raw_status[`IRQ_TIMER_BIT] = i_timer_int;
        raw_status[`IRQ_EXT0_BIT]  = i_ext_irq[0];
        raw_status[`IRQ_EXT1_BIT]  = i_ext_irq[1];
    end

    assign irq_status  = raw_status & irq_en_q;
    assign firq_status = raw_status & firq_en_q;

    // ------------------------------------------------------------
    // Enable masks and soft interrupt, set and clear by 1 bits
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack  <= 1'b0;
            irq_en_q  <= '0;
            firq_en_q <= '0;
            soft_q    <= 1'b0;
            o_irq     <= 1'b0;
            o_firq    <= 1'b0;
        end else begin
            o_wb_ack <= wb_start;
            if (wb_wr) begin
                case (reg_ofs)
                    `IC_IRQ_EN_SET:  irq_en_q  <= irq_en_q | wr_bits;
                    `IC_IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~wr_bits;
                    `IC_FIRQ_EN_SET: firq_en_q <= firq_en_q | wr_bits;
                    `IC_FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~wr_bits;
                    `IC_SOFT_SET:    soft_q    <= soft_q | wr_bits[`IRQ_SOFT_BIT];
                    `IC_SOFT_CLR:    soft_q    <= soft_q & ~wr_bits[`IRQ_SOFT_BIT];
                    default:         soft_q    <= soft_q;
                endcase
            end
            // Core pins trail the masked status by one cycle
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
        end
    end

    // Status reads, set and clear offsets read as zero
    always_ff @(posedge i_clk) begin
        if (wb_start && !i_wb_we) begin
            case (reg_ofs)
                `IC_IRQ_STATUS:  o_wb_dat <= wb_dat_t'(irq_status);
                `IC_FIRQ_STATUS: o_wb_dat <= wb_dat_t'(firq_status);
                `IC_RAW_STATUS:  o_wb_dat <= wb_dat_t'(raw_status);
                default:         o_wb_dat <= '0;
            endcase
        end
    end

endmodule

// ==== source/amber_system.sv ====
`timescale 1ns/1ps

module amber_system (
    input  logic                    i_clk,
    input  logic                    i_rst_n,

    // Wishbone master port
    input  amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  amber_sys_pkg::wb_sel_t  i_wb_sel,
    input  logic                    i_wb_we,
    input  amber_sys_pkg::wb_dat_t  i_wb_dat,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    output amber_sys_pkg::wb_dat_t  o_wb_dat,
    output logic                    o_wb_ack,
    output logic                    o_wb_err,

    // Interrupts
    input  logic [1:0]              i_ext_irq,
    output logic                    o_irq,
    output logic                    o_firq
);

    import amber_sys_pkg::*;

    logic    boot_stb;
    logic    timer_stb;
    logic    ic_stb;
    wb_dat_t boot_dat;
    wb_dat_t timer_dat;
    wb_dat_t ic_dat;
    logic    boot_ack;
    logic    timer_ack;
    logic    ic_ack;
    logic    timer_int;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    wb_slave_decoder u_wb_slave_decoder (
        .i_clk          ( i_clk         ),
        .i_rst_n        ( i_rst_n       ),
        .i_wb_adr       ( i_wb_adr      ),
        .i_wb_cyc       ( i_wb_cyc      ),
        .i_wb_stb       ( i_wb_stb      ),
        .o_boot_stb     ( boot_stb      ),
        .o_timer_stb    ( timer_stb     ),
        .o_ic_stb       ( ic_stb        ),
        .i_boot_dat     ( boot_dat      ),
        .i_timer_dat    ( timer_dat     ),
        .i_ic_dat       ( ic_dat        ),
        .i_boot_ack     ( boot_ack      ),
        .i_timer_ack    ( timer_ack     ),
        .i_ic_ack       ( ic_ack        ),
        .o_wb_dat       ( o_wb_dat      ),
        .o_wb_ack       ( o_wb_ack      ),
        .o_wb_err       ( o_wb_err      )
    );

    // ------------------------------------------------------------
    // Slaves
    // ------------------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk          ( i_clk         ),
        .i_rst_n        ( i_rst_n       ),
        .i_wb_adr       ( i_wb_adr      ),
        .i_wb_sel       ( i_wb_sel      ),
        .i_wb_we        ( i_wb_we       ),
        .i_wb_stb       ( boot_stb      ),
        .i_wb_dat       ( i_wb_dat      ),
        .o_wb_dat       ( boot_dat      ),
        .o_wb_ack       ( boot_ack      )
    );

    timer_module u_timer_module (
        .i_clk          ( i_clk         ),
        .i_rst_n        ( i_rst_n       ),
        .i_wb_adr       ( i_wb_adr      ),
        .i_wb_we        ( i_wb_we       ),
        .i_wb_stb       ( timer_stb     ),
        .i_wb_dat       ( i_wb_dat      ),
        .o_wb_dat       ( timer_dat     ),
        .o_wb_ack       ( timer_ack     ),
        .o_timer_int    ( timer_int     )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk          ( i_clk         ),
        .i_rst_n        ( i_rst_n       ),
        .i_wb_adr       ( i_wb_adr      ),
        .i_wb_we        ( i_wb_we       ),
        .i_wb_stb       ( ic_stb        ),
        .i_wb_dat       ( i_wb_dat      ),
        .i_timer_int    ( timer_int     ),
        .i_ext_irq      ( i_ext_irq     ),
        .o_wb_dat       ( ic_dat        ),
        .o_wb_ack       ( ic_ack        ),
        .o_irq          ( o_irq         ),
        .o_firq         ( o_firq        )
    );

endmodule

// ==== test/amber_system_checker.sv ====
`timescale 1ns/1ps

module amber_system_checker (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_wb_cyc,
    input  logic i_wb_stb,
    input  logic i_wb_ack,
    input  logic i_wb_err
);

    // Latched by any failing assertion below
    logic violation = 1'b0;

    // ------------------------------------------------------------
    // Wishbone classic response rules
    // ------------------------------------------------------------
    a_ack_err_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_wb_ack && i_wb_err)
    ) else begin
        violation = 1'b1;
        $error("ack and err are high in the same cycle");
    end

    // A response needs a strobe one cycle earlier
    a_resp_after_stb: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_ack || i_wb_err) |-> $past(i_wb_cyc && i_wb_stb)
    ) else begin
        violation = 1'b1;
        $error("response without a strobe in the previous cycle");
    end

    // Single cycle pulse
    a_resp_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_ack || i_wb_err) |=> !(i_wb_ack || i_wb_err)
    ) else begin
        violation = 1'b1;
        $error("response held for two cycles");
    end

endmodule

// ==== test/tb_amber_system.sv ====
`timescale 1ns/1ps

`include "amber_sys_consts.svh"

module tb_amber_system;

    import amber_sys_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int N_MEM       = 200;
    localparam int N_UNMAPPED  = 20;
    localparam int N_IRQ_STEPS = 40;
    localparam int MAX_LOAD    = 40;
    localparam int N_TRANS     = 3 + 2*N_MEM + 2*N_UNMAPPED + 10 + 4*N_IRQ_STEPS;
    localparam int WD_CYCLES   = N_TRANS*4 + MAX_LOAD + 4 + 200;

    logic       clk;
    logic       rst_n;
    wb_adr_t    wb_adr;
    wb_sel_t    wb_sel;
    logic       wb_we;
    wb_dat_t    wb_dat_w;
    logic       wb_cyc;
    logic       wb_stb;
    wb_dat_t    wb_dat_r;
    logic       wb_ack;
    logic       wb_err;
    logic [1:0] ext_irq;
    logic       irq;
    logic       firq;
    integer     seed;

    // Boot memory model, data plus the bytes written so far
    wb_dat_t    mem_model [0:`BOOT_MEM_WORDS-1];
    wb_sel_t    mem_valid [0:`BOOT_MEM_WORDS-1];

    // Interrupt controller model
    irq_src_t   irq_en_m;
    irq_src_t   firq_en_m;
    logic       soft_m;

    amber_system dut_i (
        .i_clk      ( clk       ),
        .i_rst_n    ( rst_n     ),
        .i_wb_adr   ( wb_adr    ),
        .i_wb_sel   ( wb_sel    ),
        .i_wb_we    ( wb_we     ),
        .i_wb_dat   ( wb_dat_w  ),
        .i_wb_cyc   ( wb_cyc    ),
        .i_wb_stb   ( wb_stb    ),
        .o_wb_dat   ( wb_dat_r  ),
        .o_wb_ack   ( wb_ack    ),
        .o_wb_err   ( wb_err    ),
        .i_ext_irq  ( ext_irq   ),
        .o_irq      ( irq       ),
        .o_firq     ( firq      )
    );

    bind amber_system amber_system_checker u_checker (
        .i_clk      ( i_clk     ),
        .i_rst_n    ( i_rst_n   ),
        .i_wb_cyc   ( i_wb_cyc  ),
        .i_wb_stb   ( i_wb_stb  ),
        .i_wb_ack   ( o_wb_ack  ),
        .i_wb_err   ( o_wb_err  )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_dat(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                                        name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected %b actual %b",
                                        name, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // Bus access, response due one cycle after the strobe
    // ------------------------------------------------------------
    task automatic bus_xfer(input wb_adr_t adr, input wb_sel_t sel, input logic we,
                            input wb_dat_t dat, output wb_dat_t rdat,
                            output logic got_ack, output logic got_err);
        @(posedge clk);
        wb_adr   <= adr;
        wb_sel   <= sel;
        wb_we    <= we;
        wb_dat_w <= dat;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        // Strobe not yet sampled by any slave
        @(negedge clk);
        if (wb_ack || wb_err) begin
            stop_with_failure($sformatf("Response came in the strobe cycle, address %h", adr));
        end
        @(negedge clk);
        if (!wb_ack && !wb_err) begin
            stop_with_failure($sformatf("No response one cycle after the strobe, address %h",
                                        adr));
        end
        rdat    = wb_dat_r;
        got_ack = wb_ack;
        got_err = wb_err;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input string name, input wb_adr_t adr, input wb_sel_t sel,
                            input wb_dat_t dat);
        wb_dat_t rdat;
        logic    got_ack;
        logic    got_err;
        bus_xfer(adr, sel, 1'b1, dat, rdat, got_ack, got_err);
        check_bit({name, " ack"}, 1'b1, got_ack);
        check_bit({name, " err"}, 1'b0, got_err);
    endtask

    task automatic wb_read(input string name, input wb_adr_t adr, output wb_dat_t rdat);
        logic got_ack;
        logic got_err;
        bus_xfer(adr, 4'hF, 1'b0, 32'h0, rdat, got_ack, got_err);
        check_bit({name, " ack"}, 1'b1, got_ack);
        check_bit({name, " err"}, 1'b0, got_err);
    endtask

    function automatic wb_adr_t timer_reg_adr(input logic [7:0] ofs);
        return {`TIMER_REGION, 16'h0000, ofs};
    endfunction

    function automatic wb_adr_t ic_reg_adr(input logic [7:0] ofs);
        return {`IC_REGION, 16'h0000, ofs};
    endfunction

    // Random upper bits, so every access also checks the wrap
    function automatic wb_adr_t boot_word_adr(input logic [7:0] idx);
        return {`BOOT_MEM_REGION, 14'($random(seed)), idx, 2'b00};
    endfunction

    function automatic wb_dat_t byte_mask(input wb_sel_t sel);
        wb_dat_t m;
        m = '0;
        for (int b = 0; b < `WB_SWIDTH; b++) begin
            if (sel[b]) begin
                m[b*8 +: 8] = 8'hFF;
            end
        end
        return m;
    endfunction

    function automatic irq_src_t raw_model(input logic [1:0] ext, input logic tmr);
        irq_src_t r;
        r                 = '0;
        r[`IRQ_SOFT_BIT]  = soft_m;
        r[`IRQ_TIMER_BIT] = tmr;
        r[`IRQ_EXT0_BIT]  = ext[0];
        r[`IRQ_EXT1_BIT]  = ext[1];
        return r;
    endfunction

    // ------------------------------------------------------------
    // Watchdog and assertion monitor
    // ------------------------------------------------------------
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog timeout, the test sequence did not finish in time");
    end

    always @(negedge clk) begin
        if (dut_i.u_checker.violation) begin
            stop_with_failure("A bus handshake assertion failed in the checker");
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        wb_dat_t    rdat;
        wb_dat_t    load_val;
        wb_dat_t    dat;
        wb_dat_t    mask;
        wb_sel_t    sel;
        logic [7:0] idx;
        logic [7:0] region;
        logic [7:0] ofs;
        logic [1:0] ext;
        logic       we;
        logic       got_ack;
        logic       got_err;
        irq_src_t   raw_m;
        irq_src_t   bits;
        int         op;
        int         wait_cycles;
        logic [7:0] mem_idx [0:N_MEM-1];

        seed      = 32'h0c45_9aec;
        irq_en_m  = '0;
        firq_en_m = '0;
        soft_m    = 1'b0;
        for (int i = 0; i < `BOOT_MEM_WORDS; i++) begin
            mem_model[i] = '0;
            mem_valid[i] = '0;
        end
        rst_n    <= 1'b0;
        wb_adr   <= '0;
        wb_sel   <= '0;
        wb_we    <= 1'b0;
        wb_dat_w <= '0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        ext_irq  <= 2'b00;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_bit("reset o_irq", 1'b0, irq);
        check_bit("reset o_firq", 1'b0, firq);
        check_bit("reset o_wb_ack", 1'b0, wb_ack);
        check_bit("reset o_wb_err", 1'b0, wb_err);
        wb_read("reset raw status", ic_reg_adr(`IC_RAW_STATUS), rdat);
        check_dat("reset raw status", 32'h0, rdat);
        wb_read("reset timer value", timer_reg_adr(`TM_VALUE), rdat);
        check_dat("reset timer value", 32'h0, rdat);
        wb_read("reset timer ctrl", timer_reg_adr(`TM_CTRL), rdat);
        check_dat("reset timer ctrl", 32'h0, rdat);

        // Boot memory, byte masked writes then reads
        for (int i = 0; i < N_MEM; i++) begin
            idx        = 8'($random(seed));
            sel        = 4'($random(seed));
            dat        = $random(seed);
            mem_idx[i] = idx;
            wb_write("boot write", boot_word_adr(idx), sel, dat);
            mask           = byte_mask(sel);
            mem_model[idx] = (mem_model[idx] & ~mask) | (dat & mask);
            mem_valid[idx] = mem_valid[idx] | sel;
        end
        for (int i = 0; i < N_MEM; i++) begin
            idx = mem_idx[i];
            wb_read("boot read", boot_word_adr(idx), rdat);
            mask = byte_mask(mem_valid[idx]);
            check_dat("boot read", mem_model[idx] & mask, rdat & mask);
        end

        // Unmapped regions answer with err and zero data
        for (int i = 0; i < N_UNMAPPED; i++) begin
            region = 8'($random(seed));
            while (region == `BOOT_MEM_REGION || region == `TIMER_REGION ||
                   region == `IC_REGION) begin
                region = 8'($random(seed));
            end
            idx = mem_idx[{$random(seed)} % N_MEM];
            we  = 1'($random(seed));
            dat = $random(seed);
            bus_xfer({region, 14'($random(seed)), idx, 2'b00}, 4'hF, we, dat,
                     rdat, got_ack, got_err);
            check_bit("unmapped err", 1'b1, got_err);
            check_bit("unmapped ack", 1'b0, got_ack);
            check_dat("unmapped data", 32'h0, rdat);
            wb_read("boot after unmapped", boot_word_adr(idx), rdat);
            mask = byte_mask(mem_valid[idx]);
            check_dat("boot after unmapped", mem_model[idx] & mask, rdat & mask);
        end

        // Timer expiry reaches o_irq L+2 cycles after the enabling ack
        load_val = 2 + ({$random(seed)} % (MAX_LOAD - 1));
        bits     = '0;
        bits[`IRQ_TIMER_BIT] = 1'b1;
        wb_write("timer irq enable", ic_reg_adr(`IC_IRQ_EN_SET), 4'hF, wb_dat_t'(bits));
        irq_en_m = irq_en_m | bits;
        wb_write("timer load", timer_reg_adr(`TM_LOAD), 4'hF, load_val);
        wb_write("timer enable", timer_reg_adr(`TM_CTRL), 4'hF, 32'h1);
        wait_cycles = 1;
        @(negedge clk);
        while (!irq) begin
            if (wait_cycles > MAX_LOAD + 4) begin
                stop_with_failure("Timer interrupt never reached o_irq");
            end
            wait_cycles++;
            @(negedge clk);
        end
        check_dat("timer irq delay", load_val + 2, wb_dat_t'(wait_cycles));
        check_bit("timer o_firq", 1'b0, firq);
        wb_read("timer raw status", ic_reg_adr(`IC_RAW_STATUS), rdat);
        check_dat("timer raw status", wb_dat_t'(bits), rdat);
        wb_read("timer load readback", timer_reg_adr(`TM_LOAD), rdat);
        check_dat("timer load readback", load_val, rdat);
        // Stop the count first so no late expiry sets pending again
        wb_write("timer disable", timer_reg_adr(`TM_CTRL), 4'hF, 32'h0);
        wb_write("timer clear", timer_reg_adr(`TM_CLEAR), 4'hF, 32'h1);
        @(negedge clk);
        check_bit("timer o_irq after clear", 1'b0, irq);

        // Enable masks, soft bit and external lines
        for (int s = 0; s < N_IRQ_STEPS; s++) begin
            @(posedge clk);
            ext     = 2'($random(seed));
            ext_irq <= ext;
            op      = {$random(seed)} % 6;
            dat     = $random(seed);
            bits    = dat[`IRQ_SOURCES-1:0];
            case (op)
                0: begin
                    ofs      = `IC_IRQ_EN_SET;
                    irq_en_m = irq_en_m | bits;
                end
                1: begin
                    ofs      = `IC_IRQ_EN_CLR;
                    irq_en_m = irq_en_m & ~bits;
                end
                2: begin
                    ofs       = `IC_FIRQ_EN_SET;
                    firq_en_m = firq_en_m | bits;
                end
                3: begin
                    ofs       = `IC_FIRQ_EN_CLR;
                    firq_en_m = firq_en_m & ~bits;
                end
                4: begin
                    ofs    = `IC_SOFT_SET;
                    soft_m = soft_m | bits[`IRQ_SOFT_BIT];
                end
                default: begin
                    ofs    = `IC_SOFT_CLR;
                    soft_m = soft_m & ~bits[`IRQ_SOFT_BIT];
                end
            endcase
            wb_write("ic mask write", ic_reg_adr(ofs), 4'hF, dat);
            @(negedge clk);
            raw_m = raw_model(ext, 1'b0);
            check_bit("ic o_irq", |(raw_m & irq_en_m), irq);
            check_bit("ic o_firq", |(raw_m & firq_en_m), firq);
            wb_read("ic irq status", ic_reg_adr(`IC_IRQ_STATUS), rdat);
            check_dat("ic irq status", wb_dat_t'(raw_m & irq_en_m), rdat);
            wb_read("ic firq status", ic_reg_adr(`IC_FIRQ_STATUS), rdat);
            check_dat("ic firq status", wb_dat_t'(raw_m & firq_en_m), rdat);
        end

        repeat (2) @(posedge clk);
        if (!dut_i.u_checker.violation) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("A bus handshake assertion failed in the checker");
        end
    end

endmodule

// ==== src.f ====
+incdir+common
common/amber_sys_pkg.sv
source/wb_slave_decoder.sv
source/boot_mem.sv
timer/timer_module.sv
source/interrupt_controller.sv
source/amber_system.sv
test/amber_system_checker.sv
test/tb_amber_system.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_amber_system --Mdir "$OBJ" -o vsim -f src.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/vsim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1
